// ==== all.f ====
+incdir+logic
logic/isaPkg.sv
logic/ctrlPkg.sv
logic/programCounter.sv
logic/instrMemory.sv
logic/hazardDetect.sv
logic/instrDecode.sv
logic/fetchStage.sv
testbench/fetchTb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f all.f --top-module fetchTb -o fetchSim &&
./obj_dir/fetchSim | tee /dev/stderr | grep -qF "Simulation finished: PASS" &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: simulation failed"; exit 1; }

// ==== testbench/fetchTb.sv ====
// Testbench for the fetch and decode front end
// Reference PC and hazard model, concurrent checks, directed programs
`timescale 1ns/1ps
`include "fetch_settings.svh"

module fetchTb import isaPkg::*, ctrlPkg::*;;
    localparam int idxBits        = $clog2(`IMEM_DEPTH);
    localparam int roundCount     = 10;    // Reset and load rounds over all tests
    localparam int cyclesPerRound = 24;
    localparam int limitNs        = roundCount * cyclesPerRound * 40 + 2000;

    logic        clk = 1'b0;
    logic        arstN;
    logic        pcSel;
    logic [15:0] brnchAddr;
    logic [15:0] rs = 16'h0000;
    logic [15:0] imm = 16'h0000;
    logic        loadEn;
    logic [15:0] loadAddr;
    logic [15:0] loadData;
    logic [15:0] pc;
    logic [15:0] instrOut;
    logic [4:0]  aluCtrl;
    logic [2:0]  writeRegAddr;
    logic        regWrite, regJmp, memEnable, memWr, val2Reg, aluSel;
    immSelT      immSel;
    linkSelT     linkReg;
    logic        halt, siic, bFlag, ctrlErr, validN;

    logic [15:0] prog [`IMEM_DEPTH];   // Mirror of the loaded words
    logic [15:0] loadAddrQ [$];
    logic [15:0] loadDataQ [$];
    logic [8:0]  jmpLow = 9'h000;      // Low bits of every rs + imm sum
    logic [31:0] seed = 32'h898d_3d98;
    int          errCount = 0;
    int          errMark = 0;
    int          passCount = 0;
    int          failCount = 0;
    int          bubbleCount = 0;

    // Reference model state
    logic [15:0] mPc, mEpc, rawWord, expWord;
    logic        mLoad, bubble;
    logic [2:0]  mDest;
    opcodeT      expOp;

    fetchStage fetchStage_i (
        .clk(clk), .arstN(arstN), .pcSel(pcSel), .brnchAddr(brnchAddr),
        .rs(rs), .imm(imm), .loadEn(loadEn), .loadAddr(loadAddr), .loadData(loadData),
        .pc(pc), .instrOut(instrOut), .aluCtrl(aluCtrl), .regWrite(regWrite),
        .writeRegAddr(writeRegAddr), .regJmp(regJmp), .memEnable(memEnable),
        .memWr(memWr), .val2Reg(val2Reg), .aluSel(aluSel), .immSel(immSel),
        .linkReg(linkReg), .halt(halt), .siic(siic), .bFlag(bFlag),
        .ctrlErr(ctrlErr), .validN(validN)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [idxBits-1:0] wordIndex(input logic [15:0] a);
        logic [15:0] w;
        w = (a >> 1) % 16'(`IMEM_DEPTH);    // Wraps like the memory
        return w[idxBits-1:0];
    endfunction

    function automatic logic [15:0] iWord(input opcodeT op, input logic [2:0] rsF,
                                          input logic [2:0] rdF, input logic [4:0] immF);
        return {op, rsF, rdF, immF};
    endfunction

    function automatic logic writesReg(input opcodeT op);
        case (op)
            ADDI, SUBI, XORI, ANDNI, ROLI, SLLI, RORI, SRLI, LD, STU, LBI, SLBI,
            BTR, ALU_R, SHIFT_R, SEQ, SLT, SLE, SCO, JAL, JALR: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    // {memEnable, memWr, val2Reg}
    function automatic logic [2:0] memBits(input opcodeT op);
        case (op)
            ST, STU: return 3'b110;
            LD:      return 3'b101;
            default: return 3'b000;
        endcase
    endfunction

    // {bFlag, halt, siic, regJmp}
    function automatic logic [3:0] flowBits(input opcodeT op);
        case (op)
            BEQZ, BNEZ, BLTZ, BGEZ: return 4'b1000;
            HALT:     return 4'b0100;
            SIIC:     return 4'b0010;
            JR, JALR: return 4'b0001;
            default:  return 4'b0000;
        endcase
    endfunction

    // {aluSel, immSel} by immediate width and extension of each format
    function automatic logic [3:0] operandBits(input opcodeT op);
        case (op)
            ADDI, SUBI, ST, LD, STU:             return {1'b1, IMM5_SIGN};
            XORI, ANDNI, ROLI, SLLI, RORI, SRLI: return {1'b1, IMM5_ZERO};
            LBI:                                 return {1'b1, IMM8_SIGN};
            SLBI:                                return {1'b1, IMM8_ZERO};
            BEQZ, BNEZ, BLTZ, BGEZ, JR, JALR:    return {1'b0, IMM8_SIGN};
            J, JAL:                              return {1'b0, IMM11_SIGN};
            default:                             return {1'b0, IMM5_ZERO};
        endcase
    endfunction

    function automatic logic [1:0] linkKind(input opcodeT op);
        if (op == JAL || op == JALR) begin
            return LINK_PC2;
        end
        return LINK_NONE;
    endfunction

    function automatic logic [2:0] destReg(input logic [15:0] w);
        case (opcodeT'(w[15:11]))
            LBI, SLBI, STU: return w[10:8];
            BTR, ALU_R, SHIFT_R, SEQ, SLT, SLE, SCO: return w[4:2];
            JAL, JALR: return `LINK_REG;
            default: return w[7:5];
        endcase
    endfunction

    // Does word w read register r through rs or rt
    function automatic logic usesReg(input logic [15:0] w, input logic [2:0] r);
        logic rsUsed;
        logic rtUsed;
        case (opcodeT'(w[15:11]))
            HALT, NOP, SIIC, RTI, LBI, J, JAL: rsUsed = 1'b0;
            default: rsUsed = 1'b1;
        endcase
        case (opcodeT'(w[15:11]))
            BTR, ALU_R, SHIFT_R, SEQ, SLT, SLE, SCO: rtUsed = 1'b1;
            default: rtUsed = 1'b0;
        endcase
        return (rsUsed && w[10:8] == r) || (rtUsed && w[7:5] == r);
    endfunction

    always_comb begin
        rawWord = prog[wordIndex(mPc)];
        bubble  = mLoad && usesReg(rawWord, mDest);
        expWord = bubble ? `NOP_INSTR : rawWord;
        expOp   = opcodeT'(expWord[15:11]);
    end

    // Next PC in priority order
    always @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            mPc   <= 16'h0000;
            mEpc  <= 16'h0000;
            mLoad <= 1'b0;
            mDest <= 3'd0;
        end else begin
            mLoad <= (expOp == LD);
            mDest <= destReg(expWord);
            if (bubble || expOp == HALT) begin
                mPc <= mPc;
            end else if (pcSel) begin
                mPc <= brnchAddr;
            end else if (expOp == JR || expOp == JALR) begin
                mPc <= rs + imm;
            end else if (expOp == SIIC) begin
                mEpc <= mPc + 16'd2;
                mPc  <= `ISR_VECTOR;
            end else if (expOp == RTI) begin
                mPc <= mEpc;
            end else begin
                mPc <= mPc + 16'd2;
            end
        end
    end

    // Bubbles issued by the DUT, no program word is a NOP
    always @(posedge clk) begin
        if (arstN && instrOut == `NOP_INSTR) begin
            bubbleCount <= bubbleCount + 1;
        end
    end

    // Random register operands, the sum always lands on jmpLow
    always @(negedge clk) begin
        seed = xorshift(seed);
        rs   = seed[15:0];
        imm  = {seed[31:25], jmpLow} - seed[15:0];
    end

    pcCheck: assert property (@(posedge clk) disable iff (!arstN) pc == mPc)
        else begin
            $display("Error: pc expected %h actual %h", $sampled(mPc), $sampled(pc));
            errCount++;
        end
    instrCheck: assert property (@(posedge clk) disable iff (!arstN) instrOut == expWord)
        else begin
            $display("Error: instrOut expected %h actual %h", $sampled(expWord),
                     $sampled(instrOut));
            errCount++;
        end
    regWriteCheck: assert property (@(posedge clk) disable iff (!arstN)
                                    regWrite == writesReg(expOp))
        else begin
            $display("Error: regWrite expected %h actual %h", writesReg($sampled(expOp)),
                     $sampled(regWrite));
            errCount++;
        end
    destCheck: assert property (@(posedge clk) disable iff (!arstN)
                                writeRegAddr == destReg(expWord))
        else begin
            $display("Error: writeRegAddr expected %h actual %h", destReg($sampled(expWord)),
                     $sampled(writeRegAddr));
            errCount++;
        end
    memCheck: assert property (@(posedge clk) disable iff (!arstN)
                               {memEnable, memWr, val2Reg} == memBits(expOp))
        else begin
            $display("Error: {memEnable,memWr,val2Reg} expected %h actual %h",
                     memBits($sampled(expOp)), $sampled({memEnable, memWr, val2Reg}));
            errCount++;
        end
    flowCheck: assert property (@(posedge clk) disable iff (!arstN)
                                {bFlag, halt, siic, regJmp} == flowBits(expOp))
        else begin
            $display("Error: {bFlag,halt,siic,regJmp} expected %h actual %h",
                     flowBits($sampled(expOp)), $sampled({bFlag, halt, siic, regJmp}));
            errCount++;
        end
    aluCtrlCheck: assert property (@(posedge clk) disable iff (!arstN)
                                   aluCtrl == expWord[15:11])
        else begin
            $display("Error: aluCtrl expected %h actual %h", $sampled(expWord[15:11]),
                     $sampled(aluCtrl));
            errCount++;
        end
    operandCheck: assert property (@(posedge clk) disable iff (!arstN)
                                   {aluSel, immSel} == operandBits(expOp))
        else begin
            $display("Error: {aluSel,immSel} expected %h actual %h",
                     operandBits($sampled(expOp)), $sampled({aluSel, immSel}));
            errCount++;
        end
    linkCheck: assert property (@(posedge clk) disable iff (!arstN)
                                linkReg == linkKind(expOp))
        else begin
            $display("Error: linkReg expected %h actual %h", linkKind($sampled(expOp)),
                     $sampled(linkReg));
            errCount++;
        end
    // All 32 codes are assigned, so no word is illegal
    errFlagCheck: assert property (@(posedge clk) disable iff (!arstN)
                                   {ctrlErr, validN} == 2'b00)
        else begin
            $display("Error: {ctrlErr,validN} expected 0 actual %h",
                     $sampled({ctrlErr, validN}));
            errCount++;
        end

    task automatic putWord(input logic [15:0] addr, input logic [15:0] word);
        loadAddrQ.push_back(addr);
        loadDataQ.push_back(word);
    endtask

    // Eight reset cycles, up to eight queued words written meanwhile
    task automatic resetAndLoad();
        @(negedge clk);
        arstN = 1'b0;
        repeat (8) begin
            loadEn = (loadAddrQ.size() > 0);
            if (loadEn) begin
                loadAddr = loadAddrQ.pop_front();
                loadData = loadDataQ.pop_front();
                prog[wordIndex(loadAddr)] = loadData;
            end
            @(negedge clk);
        end
        loadEn = 1'b0;
        arstN  = 1'b1;
    endtask

    task automatic waitHalt(input int holdCycles);
        do @(negedge clk); while (!halt);
        repeat (holdCycles) @(negedge clk);
    endtask

    task automatic closeTest(input string name);
        if (errCount == errMark) begin
            passCount++;
            $display("Test %s: passed", name);
        end else begin
            failCount++;
            $display("Test %s: failed with %0d errors", name, errCount - errMark);
        end
        errMark = errCount;
    endtask

    initial begin : watchdog
        #(limitNs);
        $display("Timeout: run still going after %0d ns", limitNs);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        int          g;
        int          k;
        int          bubbleMark;
        logic [4:0]  code;
        arstN = 1'b0;
        pcSel = 1'b0;
        brnchAddr = 16'h0000;
        loadEn = 1'b0;
        loadAddr = 16'h0000;
        loadData = 16'h0000;

        for (k = 0; k < 7; k++) putWord(16'(2 * k), iWord(ADDI, 3'(k), 3'(k + 1), 5'(k)));
        putWord(16'h000e, iWord(HALT, 3'd0, 3'd0, 5'd0));
        resetAndLoad();
        waitHalt(1);
        closeTest("reset and sequential fetch");

        // Codes 8 to 31 in four rounds, then the jumps
        for (g = 0; g < 4; g++) begin
            for (k = 0; k < 6; k++) begin
                code = 5'(8 + 6 * g + k);
                putWord(16'(2 * k), iWord(opcodeT'(code), 3'(k), 3'(k + g + 1), 5'(7 * g + k)));
            end
            putWord(16'h000c, iWord(HALT, 3'd0, 3'd0, 5'd0));
            resetAndLoad();
            waitHalt(1);
        end
        jmpLow = 9'h020;
        putWord(16'h0000, iWord(J, 3'd1, 3'd2, 5'd3));
        putWord(16'h0002, iWord(JAL, 3'd2, 3'd3, 5'd4));
        putWord(16'h0004, iWord(JALR, 3'd4, 3'd5, 5'd6));
        putWord(16'h0020, iWord(HALT, 3'd0, 3'd0, 5'd0));
        resetAndLoad();
        waitHalt(1);
        closeTest("decode table");

        jmpLow    = 9'h060;
        brnchAddr = 16'h0040;
        putWord(16'h0000, iWord(ADDI, 3'd1, 3'd1, 5'd1));
        putWord(16'h0040, iWord(ADDI, 3'd2, 3'd2, 5'd2));
        putWord(16'h0042, iWord(JR, 3'd3, 3'd0, 5'd0));
        putWord(16'h0060, iWord(JR, 3'd4, 3'd0, 5'd0));    // Collides with pcSel
        putWord(16'h0080, iWord(HALT, 3'd0, 3'd0, 5'd0));
        resetAndLoad();
        pcSel = 1'b1;
        @(negedge clk);
        pcSel = 1'b0;
        while (mPc[8:0] != 9'h060) @(negedge clk);
        brnchAddr = 16'h0080;
        pcSel = 1'b1;
        @(negedge clk);
        pcSel = 1'b0;
        waitHalt(1);
        closeTest("redirects");

        putWord(16'h0000, iWord(LD, 3'd1, 3'd3, 5'd0));
        putWord(16'h0002, iWord(ADDI, 3'd3, 3'd4, 5'd1));   // Reads r3, one bubble
        putWord(16'h0004, iWord(LD, 3'd1, 3'd3, 5'd2));
        putWord(16'h0006, iWord(ADDI, 3'd5, 3'd4, 5'd1));   // Unrelated, no bubble
        putWord(16'h0008, iWord(LD, 3'd1, 3'd6, 5'd3));
        putWord(16'h000a, {SEQ, 3'd2, 3'd6, 3'd1, 2'd0});   // Hit through rt
        putWord(16'h000c, iWord(HALT, 3'd0, 3'd0, 5'd0));
        bubbleMark = bubbleCount;
        resetAndLoad();
        waitHalt(1);
        if (bubbleCount - bubbleMark != 2) begin
            $display("Load-use program gave %0d bubble cycles instead of 2",
                     bubbleCount - bubbleMark);
            errCount++;
        end
        closeTest("load-use bubble");

        putWord(16'h0000, iWord(ADDI, 3'd1, 3'd2, 5'd1));
        putWord(16'h0002, iWord(ADDI, 3'd2, 3'd3, 5'd2));
        putWord(16'h0004, iWord(SIIC, 3'd0, 3'd0, 5'd0));
        putWord(16'h0006, iWord(HALT, 3'd0, 3'd0, 5'd0));
        putWord(`ISR_VECTOR, iWord(ADDI, 3'd4, 3'd5, 5'd3));
        putWord(`ISR_VECTOR + 16'd2, iWord(RTI, 3'd0, 3'd0, 5'd0));
        resetAndLoad();
        waitHalt(1);
        closeTest("interrupt and return");

        putWord(16'h0000, iWord(ADDI, 3'd1, 3'd1, 5'd1));
        putWord(16'h0002, iWord(HALT, 3'd0, 3'd0, 5'd0));
        resetAndLoad();
        waitHalt(0);
        brnchAddr = 16'h0000;
        pcSel = 1'b1;                                       // Halt outranks it
        @(negedge clk);
        pcSel = 1'b0;
        repeat (4) @(negedge clk);
        closeTest("halt");

        $display("Tests: %0d passed, %0d failed", passCount, failCount);
        if (failCount == 0 && errCount == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== logic/fetchStage.sv ====
// Fetch and decode front end
// PC, instruction store, load-use hazard unit and control decoder
`timescale 1ns/1ps
`include "fetch_settings.svh"

module fetchStage import ctrlPkg::*; (
    input  logic        clk,
    input  logic        arstN,
    input  logic        pcSel,
    input  logic [15:0] brnchAddr,
    input  logic [15:0] rs,
    input  logic [15:0] imm,
    input  logic        loadEn,
    input  logic [15:0] loadAddr,
    input  logic [15:0] loadData,
    output logic [15:0] pc,
    output logic [15:0] instrOut,
    output logic [4:0]  aluCtrl,
    output logic        regWrite,
    output logic [2:0]  writeRegAddr,
    output logic        regJmp,
    output logic        memEnable,
    output logic        memWr,
    output logic        val2Reg,
    output logic        aluSel,
    output immSelT      immSel,
    output linkSelT     linkReg,
    output logic        halt,
    output logic        siic,
    output logic        bFlag,
    output logic        ctrlErr,
    output logic        validN
);
    logic [15:0] instr;         // Raw word from memory
    logic        stall;
    logic        rti;

    programCounter programCounter_i (
        .clk(clk), .arstN(arstN),
        .stall(stall), .halt(halt),
        .pcSel(pcSel), .brnchAddr(brnchAddr),
        .regJmp(regJmp), .rs(rs), .imm(imm),
        .siic(siic), .rti(rti),
        .pc(pc)
    );

    instrMemory #(.depth(`IMEM_DEPTH)) instrMemory_i (
        .clk(clk), .addr(pc),
        .loadEn(loadEn), .loadAddr(loadAddr), .loadData(loadData),
        .instr(instr)
    );

    hazardDetect hazardDetect_i (
        .clk(clk), .arstN(arstN), .instr(instr),
        .memEnable(memEnable), .memWr(memWr), .writeRegAddr(writeRegAddr),
        .issuedInstr(instrOut), .stall(stall)
    );

    // Decodes the issued word, bubble included
    instrDecode instrDecode_i (
        .instr(instrOut), .aluCtrl(aluCtrl),
        .regWrite(regWrite), .writeRegAddr(writeRegAddr), .regJmp(regJmp),
        .memEnable(memEnable), .memWr(memWr), .val2Reg(val2Reg),
        .aluSel(aluSel), .immSel(immSel), .linkReg(linkReg),
        .halt(halt), .siic(siic), .rti(rti), .bFlag(bFlag),
        .ctrlErr(ctrlErr), .validN(validN)
    );

endmodule

// ==== logic/instrDecode.sv ====
// Control decoder, opcode to control levels
// Also selects the destination register number
`timescale 1ns/1ps
`include "fetch_settings.svh"

module instrDecode import isaPkg::*, ctrlPkg::*; (
    input  logic [15:0] instr,
    output logic [4:0]  aluCtrl,
    output logic        regWrite,
    output logic [2:0]  writeRegAddr,
    output logic        regJmp,
    output logic        memEnable,
    output logic        memWr,
    output logic        val2Reg,    // Write back memory data
    output logic        aluSel,     // Immediate as second operand
    output immSelT      immSel,
    output linkSelT     linkReg,
    output logic        halt,
    output logic        siic,
    output logic        rti,
    output logic        bFlag,
    output logic        ctrlErr,
    output logic        validN
);
    instrWordT word;
    destSelT   destSel;

    assign word    = instr;
    assign aluCtrl = word.r.opcode;

    always_comb begin
        regWrite  = 1'b0;
        regJmp    = 1'b0;
        memEnable = 1'b0;
        memWr     = 1'b0;
        val2Reg   = 1'b0;
        aluSel    = 1'b0;
        immSel    = IMM5_ZERO;
        linkReg   = LINK_NONE;
        halt      = 1'b0;
        siic      = 1'b0;
        rti       = 1'b0;
        bFlag     = 1'b0;
        ctrlErr   = 1'b0;
        validN    = 1'b0;
        destSel   = RD_IFMT;
        case (word.i.opcode)
            HALT: halt = 1'b1;
            NOP:  ;                             // Bubble, all levels low
            SIIC: siic = 1'b1;
            RTI:  rti  = 1'b1;
            ADDI, SUBI: begin
                regWrite = 1'b1;
                aluSel   = 1'b1;
                immSel   = IMM5_SIGN;
            end
            XORI, ANDNI, ROLI, SLLI, RORI, SRLI: begin
                regWrite = 1'b1;
                aluSel   = 1'b1;
            end
            ST, LD, STU: begin
                memEnable = 1'b1;
                memWr     = (word.i.opcode != LD);
                val2Reg   = (word.i.opcode == LD);
                regWrite  = (word.i.opcode != ST);
                aluSel    = 1'b1;
                immSel    = IMM5_SIGN;
                destSel   = (word.i.opcode == STU) ? RS_FIELD : RD_IFMT;
            end
            LBI, SLBI: begin
                regWrite = 1'b1;
                aluSel   = 1'b1;
                immSel   = (word.i.opcode == LBI) ? IMM8_SIGN : IMM8_ZERO;
                destSel  = RS_FIELD;
            end
            BTR, SHIFT_R, ALU_R, SEQ, SLT, SLE, SCO: begin
                regWrite = 1'b1;
                destSel  = RD_RFMT;
            end
            BEQZ, BNEZ, BLTZ, BGEZ: begin
                bFlag  = 1'b1;
                immSel = IMM8_SIGN;
            end
            J: immSel = IMM11_SIGN;
            JR: begin
                regJmp = 1'b1;
                immSel = IMM8_SIGN;
            end
            JAL, JALR: begin
                regJmp   = (word.i.opcode == JALR);
                regWrite = 1'b1;
                immSel   = (word.i.opcode == JAL) ? IMM11_SIGN : IMM8_SIGN;
                linkReg  = LINK_PC2;
                destSel  = LINK;
            end
            default: begin                      // Illegal, nothing written
                ctrlErr = 1'b1;
                validN  = 1'b1;
            end
        endcase
    end

    always_comb begin
        case (destSel)
            RS_FIELD: writeRegAddr = word.i.rs;
            RD_RFMT:  writeRegAddr = word.r.rd;
            LINK:     writeRegAddr = `LINK_REG;
            default:  writeRegAddr = word.i.rd;
        endcase
    end

endmodule

// ==== logic/hazardDetect.sv ====
// Load-use hazard unit
// Swaps a dependent word for a NOP and stalls the PC one cycle
`timescale 1ns/1ps
`include "fetch_settings.svh"

module hazardDetect import isaPkg::*; (
    input  logic        clk,
    input  logic        arstN,
    input  logic [15:0] instr,
    input  logic        memEnable,      // Decoded from the issued word
    input  logic        memWr,
    input  logic [2:0]  writeRegAddr,
    output logic [15:0] issuedInstr,
    output logic        stall
);
    instrWordT  word;
    logic       prevLoad;   // Last issued word was LD
    logic [2:0] prevDest;
    logic       readsRs;
    logic       readsRt;
    logic       rsHit;
    logic       rtHit;

    assign word = instr;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            prevLoad <= 1'b0;
        end else begin
            prevLoad <= memEnable & ~memWr;
        end
    end

    always_ff @(posedge clk) begin
        prevDest <= writeRegAddr;
    end

    // Which source fields the fetched word reads
    always_comb begin
        readsRs = 1'b1;
        readsRt = 1'b0;
        case (word.r.opcode)
            HALT, NOP, SIIC, RTI, LBI, J, JAL: readsRs = 1'b0;
            BTR, SHIFT_R, ALU_R, SEQ, SLT, SLE, SCO: readsRt = 1'b1;
            default: readsRt = 1'b0;
        endcase
    end

    assign rsHit = readsRs && (word.i.rs == prevDest);
    assign rtHit = readsRt && (word.r.rt == prevDest);

    assign stall       = prevLoad && (rsHit || rtHit);
    assign issuedInstr = stall ? `NOP_INSTR : instr;   // Refetched next cycle

endmodule

// ==== logic/instrMemory.sv ====
// Instruction store, asynchronous read by PC
// Synchronous load port for filling the program during reset
`timescale 1ns/1ps
`include "fetch_settings.svh"

module instrMemory #(
    parameter int depth = `IMEM_DEPTH    // In 16-bit words
) (
    input  logic        clk,
    input  logic [15:0] addr,       // Byte address
    input  logic        loadEn,
    input  logic [15:0] loadAddr,   // Byte address, same as addr
    input  logic [15:0] loadData,
    output logic [15:0] instr
);
    localparam int idxBits = $clog2(depth);

    logic [15:0] mem [depth];
    logic [15:0] rdWord;
    logic [15:0] wrWord;

    // Word index, wrapped to the array size
    assign rdWord = (addr >> 1) % 16'(depth);
    assign wrWord = (loadAddr >> 1) % 16'(depth);

    assign instr = mem[rdWord[idxBits-1:0]];

    always_ff @(posedge clk) begin
        if (loadEn) begin
            mem[wrWord[idxBits-1:0]] <= loadData;
        end
    end

endmodule

// ==== logic/programCounter.sv ====
// Program counter with exception return register
// Next-PC priority: stall, halt, branch, register jump, SIIC, RTI, sequential
`timescale 1ns/1ps
`include "fetch_settings.svh"

module programCounter (
    input  logic        clk,
    input  logic        arstN,
    input  logic        stall,
    input  logic        halt,
    input  logic        pcSel,
    input  logic [15:0] brnchAddr,
    input  logic        regJmp,
    input  logic [15:0] rs,
    input  logic [15:0] imm,
    input  logic        siic,
    input  logic        rti,
    output logic [15:0] pc
);
    logic [15:0] pcPlus2;   // Shared by sequential path and EPC save
    logic [15:0] pcNext;
    logic [15:0] epc;
    logic [15:0] epcNext;

    assign pcPlus2 = pc + 16'd2;

    always_comb begin
        pcNext  = pcPlus2;
        epcNext = epc;
        if (stall || halt) begin
            pcNext = pc;                // Bubble or frozen core
        end else if (pcSel) begin
            pcNext = brnchAddr;
        end else if (regJmp) begin
            pcNext = rs + imm;          // JR / JALR target
        end else if (siic) begin
            epcNext = pcPlus2;
            pcNext  = `ISR_VECTOR;
        end else if (rti) begin
            pcNext = epc;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc  <= 16'h0000;
            epc <= 16'h0000;
        end else begin
            pc  <= pcNext;
            epc <= epcNext;
        end
    end

endmodule

// ==== logic/ctrlPkg.sv ====
// Control encodings shared by the decoder and later stages
// Destination, immediate and link selects
package ctrlPkg;

    // Where the write register number comes from
    typedef enum logic [1:0] {
        RS_FIELD = 2'b00,   // bits 10:8
        RD_RFMT  = 2'b01,   // bits 4:2
        LINK     = 2'b10,   // r7
        RD_IFMT  = 2'b11    // bits 7:5
    } destSelT;

    // Immediate width and extension
    typedef enum logic [2:0] {
        IMM5_ZERO  = 3'b000,
        IMM5_SIGN  = 3'b001,
        IMM8_ZERO  = 3'b010,
        IMM8_SIGN  = 3'b011,
        IMM11_SIGN = 3'b100
    } immSelT;

    // Value written to the link register
    typedef enum logic [1:0] {
        LINK_NONE = 2'b00,
        LINK_PC2  = 2'b01,
        LINK_EPC  = 2'b10
    } linkSelT;

endpackage

// ==== logic/isaPkg.sv ====
// ISA definitions for the 16-bit core
// Opcode encodings, R/I field layouts and the instruction word union
package isaPkg;

    typedef enum logic [4:0] {
        // Control
        HALT    = 5'b00000,
        NOP     = 5'b00001,
        SIIC    = 5'b00010,
        RTI     = 5'b00011,
        // Jumps
        J       = 5'b00100,
        JR      = 5'b00101,
        JAL     = 5'b00110,
        JALR    = 5'b00111,
        // Immediate arithmetic
        ADDI    = 5'b01000,
        SUBI    = 5'b01001,
        XORI    = 5'b01010,
        ANDNI   = 5'b01011,
        ROLI    = 5'b10100,
        SLLI    = 5'b10101,
        RORI    = 5'b10110,
        SRLI    = 5'b10111,
        // Branches on rs
        BEQZ    = 5'b01100,
        BNEZ    = 5'b01101,
        BLTZ    = 5'b01110,
        BGEZ    = 5'b01111,
        // Memory
        ST      = 5'b10000,
        LD      = 5'b10001,
        STU     = 5'b10011,
        // Immediate loads
        SLBI    = 5'b10010,
        LBI     = 5'b11000,
        // Register ALU
        BTR     = 5'b11001,
        SHIFT_R = 5'b11010,
        ALU_R   = 5'b11011,
        SEQ     = 5'b11100,
        SLT     = 5'b11101,
        SLE     = 5'b11110,
        SCO     = 5'b11111
    } opcodeT;

    // Register format, func picks the ALU variant
    typedef struct packed {
        opcodeT     opcode;
        logic [2:0] rs;
        logic [2:0] rt;
        logic [2:0] rd;
        logic [1:0] func;
    } rFmtT;

    // Immediate format with a 5-bit immediate
    typedef struct packed {
        opcodeT     opcode;
        logic [2:0] rs;
        logic [2:0] rd;
        logic [4:0] imm;
    } iFmtT;

    typedef union packed {
        rFmtT r;
        iFmtT i;
    } instrWordT;

endpackage

// ==== logic/fetch_settings.svh ====
// Build-time constants for the fetch front end
// Memory size, interrupt vector, bubble word and link register
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// Instruction store size in 16-bit words
`define IMEM_DEPTH 256

// PC loaded on a software interrupt
`define ISR_VECTOR 16'h0100

// Bubble word, decodes as NOP
`define NOP_INSTR 16'h0800

// Link destination for JAL and JALR
`define LINK_REG 3'd7

`endif
